/* Makefile */
VERILATOR  = verilator
TOP        = microrocReadoutTb
RTL_TOP    = microrocReadoutTop
FILELIST   = microrocReadout.f
OBJDIR     = obj_dir
BUILDFLAGS = --binary --timing --assert -j 0
LINTFLAGS  = --lint-only -Wall --timing
PASS_TEXT  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILDFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* microrocReadout.f */
+incdir+source
source/chainPkg.sv
source/acqPkg.sv
source/chainWordPacker.sv
source/chainDataFifo.sv
source/microrocDataSwitcher.sv
source/microrocReadoutTop.sv
verification/microrocReadoutTb.sv

/* source/acqPkg.sv */
`include "difReadout_defs.svh"

package acqPkg;

  ////////////////////////////////////////////////////////////////////////////
  // acquisition side of the readout path
  ////////////////////////////////////////////////////////////////////////////

  // one word of the acquisition stream
  typedef struct packed {
    logic [`DIF_WORD_WIDTH-1:0] data;      // held until the next word
    logic                       enable;    // marks a new word, one cycle
  } AcqWord;

  // switcher states
  typedef enum logic [2:0] {
    Idle        = 3'd0,
    Wait        = 3'd1,                    // acquisition running
    FifoDetect  = 3'd2,                    // pick next non-empty FIFO
    FifoRead    = 3'd3,                    // read data on FIFO output
    FifoDataOut = 3'd4,                    // word on the output
    Done        = 3'd5
  } SwitchState;

  // index of a chain FIFO
  typedef logic [$clog2(`DIF_CHAIN_COUNT)-1:0] ChainIndex;

endpackage

/* source/chainDataFifo.sv */
`include "difReadout_defs.svh"

module chainDataFifo #(
  parameter int DepthLog2 = `DIF_FIFO_DEPTH_LOG2
) (
  input  logic                       Clk,
  input  logic                       reset_n,
  input  chainPkg::ChainWord         WriteWord,
  input  logic                       ReadEnable,
  output logic [`DIF_WORD_WIDTH-1:0] ReadData,
  output logic                       Empty,
  output logic                       Overflow
);

  localparam logic [DepthLog2:0] FullCount = {1'b1, {DepthLog2{1'b0}}};

  logic [`DIF_WORD_WIDTH-1:0] mem [2**DepthLog2];
  logic [DepthLog2-1:0]       wrPtr;
  logic [DepthLog2-1:0]       rdPtr;
  logic [DepthLog2:0]         count;
  logic                       full;
  logic                       writeOk;
  logic                       readOk;

  assign full    = (count == FullCount);
  assign Empty   = (count == '0);
  assign writeOk = WriteWord.valid && !full;   // write to a full FIFO is lost
  assign readOk  = ReadEnable && !Empty;

  ////////////////////////////////////////////////////////////////////////////
  // pointers, occupancy and overflow
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      Overflow <= 1'b0;
    end
    else begin
      if (writeOk) wrPtr <= wrPtr + 1'b1;     // wraps at depth
      if (readOk)  rdPtr <= rdPtr + 1'b1;
      case ({writeOk, readOk})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (WriteWord.valid && full) begin
        Overflow <= 1'b1;                     // sticky until reset
      end
    end
  end

  // storage and registered read port
  always_ff @(posedge Clk) begin
    if (writeOk) begin
      mem[wrPtr] <= WriteWord.data;
    end
    if (readOk) begin
      ReadData <= mem[rdPtr];                 // valid one cycle after strobe
    end
  end

endmodule

/* source/chainPkg.sv */
`include "difReadout_defs.svh"

package chainPkg;

  ////////////////////////////////////////////////////////////////////////////
  // chain side of the readout path
  ////////////////////////////////////////////////////////////////////////////

  // one byte as it leaves an ASIC chain
  typedef struct packed {
    logic [7:0] data;                      // readout byte
    logic       strobe;                    // byte valid this cycle
    logic       last;                      // final byte of the chain readout
  } ChainByte;

  // two bytes packed by the chain word packer
  typedef struct packed {
    logic [`DIF_WORD_WIDTH-1:0] data;      // first byte in the high half
    logic                       valid;     // one-cycle write strobe
  } ChainWord;

endpackage

/* source/chainWordPacker.sv */
`include "difReadout_defs.svh"

module chainWordPacker (
  input  logic                Clk,
  input  logic                reset_n,
  input  chainPkg::ChainByte  ByteIn,
  output chainPkg::ChainWord  WordOut
);

  logic [7:0]                 highByte;
  logic                       halfFull;
  logic                       wordValid;
  logic [`DIF_WORD_WIDTH-1:0] wordData;

  ////////////////////////////////////////////////////////////////////////////
  // pairing control
  ////////////////////////////////////////////////////////////////////////////

  // halfFull is set while an even-index byte waits for its partner
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      halfFull  <= 1'b0;
      wordValid <= 1'b0;
    end
    else begin
      wordValid <= 1'b0;                   // single-cycle pulse
      if (ByteIn.strobe) begin
        if (halfFull) begin
          wordValid <= 1'b1;               // second byte completes word
          halfFull  <= 1'b0;
        end
        else if (ByteIn.last) begin
          wordValid <= 1'b1;               // lone last byte, padded
        end
        else begin
          halfFull <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // byte holding and word assembly
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (ByteIn.strobe) begin
      if (!halfFull) begin
        highByte <= ByteIn.data;           // first byte of a pair
      end
      if (halfFull) begin
        wordData <= {highByte, ByteIn.data};
      end
      else begin
        wordData <= {ByteIn.data, 8'h00};  // only used when last is set
      end
    end
  end

  // word leaves as a struct towards the chain FIFO
  always_comb begin
    WordOut.data  = wordData;
    WordOut.valid = wordValid;
  end

endmodule

/* source/difReadout_defs.svh */
`ifndef DIF_READOUT_DEFS_SVH
`define DIF_READOUT_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// readout path sizing
////////////////////////////////////////////////////////////////////////////

// number of front-end ASIC chains on the board
`define DIF_CHAIN_COUNT 4

// acquisition word width, two chain bytes
`define DIF_WORD_WIDTH 16

// default chain FIFO address width, 16 entries
`define DIF_FIFO_DEPTH_LOG2 4

`endif

/* source/microrocDataSwitcher.sv */
`include "difReadout_defs.svh"

module microrocDataSwitcher (
  input  logic                         Clk,
  input  logic                         reset_n,
  input  logic                         AcquisitionStart,
  input  logic                         EndReadout,
  input  logic [`DIF_WORD_WIDTH-1:0]   FifoData [`DIF_CHAIN_COUNT],
  input  logic [`DIF_CHAIN_COUNT-1:0]  FifoEmpty,
  output logic [`DIF_CHAIN_COUNT-1:0]  FifoReadEnable,
  output acqPkg::AcqWord               AcqData
);

  logic               endReadoutSync1;
  logic               endReadoutSync2;
  logic               endReadoutRise;
  acqPkg::SwitchState state;
  acqPkg::ChainIndex  chainSel;
  acqPkg::ChainIndex  pickIndex;
  logic               anyReady;

  ////////////////////////////////////////////////////////////////////////////
  // end of readout edge detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      endReadoutSync1 <= 1'b0;
      endReadoutSync2 <= 1'b0;
    end
    else begin
      endReadoutSync1 <= EndReadout;
      endReadoutSync2 <= endReadoutSync1;
    end
  end

  assign endReadoutRise = endReadoutSync1 & ~endReadoutSync2;

  ////////////////////////////////////////////////////////////////////////////
  // chain priority
  ////////////////////////////////////////////////////////////////////////////

  // scan from the top so the lowest non-empty chain wins
  always_comb begin
    anyReady  = 1'b0;
    pickIndex = '0;
    for (int i = `DIF_CHAIN_COUNT - 1; i >= 0; i--) begin
      if (!FifoEmpty[i]) begin
        anyReady  = 1'b1;
        pickIndex = acqPkg::ChainIndex'(i);
      end
    end
  end

  // strobe only while detecting, and only on a FIFO that holds data
  always_comb begin
    FifoReadEnable = '0;
    if (state == acqPkg::FifoDetect && anyReady) begin
      FifoReadEnable[pickIndex] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // acquisition FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= acqPkg::Idle;
      chainSel <= '0;
      AcqData  <= '0;
    end
    else begin
      case (state)
        acqPkg::Idle: begin
          if (AcquisitionStart) state <= acqPkg::Wait;
        end
        acqPkg::Wait: begin
          if (!AcquisitionStart) begin
            state <= acqPkg::Done;          // abort, FIFOs keep their data
          end
          else if (endReadoutRise) begin
            state <= acqPkg::FifoDetect;
          end
        end
        acqPkg::FifoDetect: begin
          if (anyReady) begin
            chainSel <= pickIndex;         // remembered for the capture
            state    <= acqPkg::FifoRead;
          end
          else begin
            state <= acqPkg::Wait;         // all drained
          end
        end
        acqPkg::FifoRead: begin
          AcqData.data   <= FifoData[chainSel];
          AcqData.enable <= 1'b1;
          state          <= acqPkg::FifoDataOut;
        end
        acqPkg::FifoDataOut: begin
          AcqData.enable <= 1'b0;          // enable lasts this state only
          state          <= acqPkg::FifoDetect;
        end
        acqPkg::Done: begin
          state <= acqPkg::Idle;
        end
        default: begin
          state <= acqPkg::Idle;
        end
      endcase
    end
  end

endmodule

/* source/microrocReadoutTop.sv */
`include "difReadout_defs.svh"

module microrocReadoutTop (
  input  logic                        Clk,
  input  logic                        reset_n,
  input  logic                        AcquisitionStart,
  input  logic                        EndReadout,
  input  chainPkg::ChainByte          ChainBytes [`DIF_CHAIN_COUNT],
  output acqPkg::AcqWord              AcqData,
  output logic [`DIF_CHAIN_COUNT-1:0] ChainOverflow
);

  chainPkg::ChainWord          chainWords [`DIF_CHAIN_COUNT];
  logic [`DIF_WORD_WIDTH-1:0]  fifoData   [`DIF_CHAIN_COUNT];
  logic [`DIF_CHAIN_COUNT-1:0] fifoEmpty;
  logic [`DIF_CHAIN_COUNT-1:0] fifoReadEnable;

  ////////////////////////////////////////////////////////////////////////////
  // one packer and one FIFO per chain
  ////////////////////////////////////////////////////////////////////////////

  for (genvar chain = 0; chain < `DIF_CHAIN_COUNT; chain++) begin : gChain

    chainWordPacker packer (
      .Clk     (Clk),
      .reset_n (reset_n),
      .ByteIn  (ChainBytes[chain]),
      .WordOut (chainWords[chain])
    );

    // packer valid is the write strobe
    chainDataFifo #(
      .DepthLog2 (`DIF_FIFO_DEPTH_LOG2)
    ) fifo (
      .Clk        (Clk),
      .reset_n    (reset_n),
      .WriteWord  (chainWords[chain]),
      .ReadEnable (fifoReadEnable[chain]),
      .ReadData   (fifoData[chain]),
      .Empty      (fifoEmpty[chain]),
      .Overflow   (ChainOverflow[chain])   // sticky per chain
    );

  end

  ////////////////////////////////////////////////////////////////////////////
  // drain onto the acquisition stream
  ////////////////////////////////////////////////////////////////////////////

  microrocDataSwitcher switcher (
    .Clk              (Clk),
    .reset_n          (reset_n),
    .AcquisitionStart (AcquisitionStart),
    .EndReadout       (EndReadout),
    .FifoData         (fifoData),
    .FifoEmpty        (fifoEmpty),
    .FifoReadEnable   (fifoReadEnable),
    .AcqData          (AcqData)
  );

endmodule

/* verification/microrocReadoutTb.sv */
`include "difReadout_defs.svh"

module microrocReadoutTb;

  localparam int FifoDepth = 1 << `DIF_FIFO_DEPTH_LOG2;
  localparam int TestCount = 5;
  localparam int MaxWords  = `DIF_CHAIN_COUNT * FifoDepth;
  // three cycles per drained word, up to four per loaded word, then a margin
  localparam int TimeoutCycles = TestCount * MaxWords * 3 + TestCount * MaxWords * 4 + 1000;

  logic                        Clk = 1'b0;
  logic                        reset_n;
  logic                        acquisitionStart;
  logic                        endReadout;
  chainPkg::ChainByte          chainBytes [`DIF_CHAIN_COUNT];
  acqPkg::AcqWord              acqData;
  logic [`DIF_CHAIN_COUNT-1:0] chainOverflow;

  logic [`DIF_WORD_WIDTH-1:0]  expectedQ [`DIF_CHAIN_COUNT][$];  // words held per FIFO
  logic [`DIF_CHAIN_COUNT-1:0] expectedOverflow;
  int                          wordsOut = 0;             // enabled words seen in this test
  logic [31:0]                 rngState = 32'd85738;
  string                       currentTest = "reset";
  int                          errorCount = 0;
  int                          testErrorStart = 0;
  int                          checksDone = 0;
  int                          testsRun = 0;
  int                          cycleCount = 0;
  int                          lastEnableCycle = -1;
  logic                        drainArmed = 1'b0;        // an end of readout is pending

  microrocReadoutTop dut (
    .Clk              (Clk),
    .reset_n          (reset_n),
    .AcquisitionStart (acquisitionStart),
    .EndReadout       (endReadout),
    .ChainBytes       (chainBytes),
    .AcqData          (acqData),
    .ChainOverflow    (chainOverflow)
  );

  always #10 Clk = ~Clk;

  always @(posedge Clk) cycleCount <= cycleCount + 1;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] randomByte();
    rngState = xorshift32(rngState);
    return rngState[7:0];
  endfunction

  // priority rule, the lowest chain still holding words goes first
  function automatic int firstLoadedChain();
    for (int c = 0; c < `DIF_CHAIN_COUNT; c++) begin
      if (expectedQ[c].size() != 0) return c;
    end
    return -1;
  endfunction

  task automatic compareWord(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    checksDone++;
    assert (expected === actual) else begin
      errorCount++;
      $display("[FAIL] %s %s expected 0x%h actual 0x%h", currentTest, what, expected, actual);
    end
  endtask

  task automatic compareNumber(input string what, input int expected, input int actual);
    checksDone++;
    assert (expected == actual) else begin
      errorCount++;
      $display("[FAIL] %s %s expected %0d actual %0d", currentTest, what, expected, actual);
    end
  endtask

  task automatic pushExpected(input int chain, input logic [15:0] word);
    if (expectedQ[chain].size() < FifoDepth) begin
      expectedQ[chain].push_back(word);
    end
    else begin
      expectedOverflow[chain] = 1'b1;      // full FIFO drops the word
    end
  endtask

  // random bytes with random idle cycles, last set on the final byte
  task automatic sendBytes(input int chain, input int count);
    logic [7:0] held;
    logic [7:0] value;
    held = 8'h00;
    for (int i = 0; i < count; i++) begin
      value = randomByte();
      @(negedge Clk);
      if (rngState[12]) begin
        chainBytes[chain].strobe = 1'b0;
        @(negedge Clk);
      end
      chainBytes[chain].data   = value;
      chainBytes[chain].strobe = 1'b1;
      chainBytes[chain].last   = (i == count - 1);
      if (i % 2 == 1) begin
        pushExpected(chain, {held, value});  // first byte high
      end
      else if (i == count - 1) begin
        pushExpected(chain, {value, 8'h00}); // lone last byte
      end
      else begin
        held = value;
      end
    end
    @(negedge Clk);
    chainBytes[chain].strobe = 1'b0;
    chainBytes[chain].last   = 1'b0;
  endtask

  task automatic pulseEndReadout(input logic expectDrain);
    lastEnableCycle = -1;
    drainArmed      = expectDrain;
    @(negedge Clk);
    endReadout = 1'b1;
    repeat (3) @(negedge Clk);
    endReadout = 1'b0;
  endtask

  // runs until the reference queues are empty
  task automatic drainChains();
    repeat (4) @(negedge Clk);             // last words reach the FIFOs
    pulseEndReadout(1'b1);
    while (firstLoadedChain() >= 0 && errorCount == testErrorStart) @(negedge Clk);
    repeat (8) @(negedge Clk);             // catches stray words, FSM back in Wait
    drainArmed = 1'b0;
  endtask

  task automatic startTest(input string name);
    currentTest    = name;
    testErrorStart = errorCount;
    wordsOut       = 0;
  endtask

  task automatic finishTest();
    compareNumber("overflow flags", int'(expectedOverflow), int'(chainOverflow));
    testsRun++;
    if (errorCount == testErrorStart) begin
      $display("test %-16s ok", currentTest);
    end
    else begin
      $display("test %-16s %0d errors", currentTest, errorCount - testErrorStart);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge Clk) begin : outputMonitor
    int                         chain;
    logic [`DIF_WORD_WIDTH-1:0] expectedWord;
    if (reset_n && acqData.enable) begin
      chain = firstLoadedChain();
      wordsOut++;
      checksDone++;
      assert (drainArmed && chain >= 0) else begin
        errorCount++;
        $display("%s: unexpected word 0x%h on the acquisition stream", currentTest,
                 acqData.data);
      end
      if (drainArmed && chain >= 0) begin
        expectedWord = expectedQ[chain].pop_front();
        compareWord("word", expectedWord, acqData.data);
        if (lastEnableCycle >= 0) begin
          compareNumber("enable gap", 3, cycleCount - lastEnableCycle);
        end
        lastEnableCycle = cycleCount;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic singleChainOrder();
    startTest("singleChain");
    sendBytes(1, 12);
    drainChains();
    compareNumber("words out", 6, wordsOut);
    finishTest();
  endtask

  task automatic oddBytePadding();
    startTest("oddByte");
    sendBytes(2, 9);                       // last word padded with 0x00
    drainChains();
    compareNumber("words out", 5, wordsOut);
    finishTest();
  endtask

  task automatic chainPriority();
    startTest("priority");
    sendBytes(3, 6);                       // loaded in reverse order
    sendBytes(2, 8);
    sendBytes(1, 4);
    sendBytes(0, 10);
    drainChains();
    compareNumber("words out", 14, wordsOut);
    finishTest();
  endtask

  task automatic enableSpacing();
    startTest("enableSpacing");
    sendBytes(0, 8);
    sendBytes(2, 8);
    repeat (12) @(negedge Clk);            // no word may leave yet
    drainChains();
    compareNumber("words out", 8, wordsOut);
    finishTest();
  endtask

  task automatic abortAndOverflow();
    startTest("abortOverflow");
    sendBytes(3, 6);
    @(negedge Clk);
    acquisitionStart = 1'b0;
    repeat (3) @(negedge Clk);
    pulseEndReadout(1'b0);                 // switcher already idle
    repeat (12) @(negedge Clk);
    acquisitionStart = 1'b1;
    repeat (3) @(negedge Clk);
    sendBytes(3, 40);                      // 3 old plus 20 new words
    drainChains();
    compareNumber("words out", FifoDepth, wordsOut);
    finishTest();
  endtask

  initial begin
    reset_n          = 1'b0;
    acquisitionStart = 1'b0;
    endReadout       = 1'b0;
    expectedOverflow = '0;
    for (int c = 0; c < `DIF_CHAIN_COUNT; c++) begin
      chainBytes[c] = '0;
    end
    repeat (3) @(posedge Clk);
    @(negedge Clk);
    reset_n          = 1'b1;
    acquisitionStart = 1'b1;
    repeat (2) @(negedge Clk);
    singleChainOrder();
    oddBytePadding();
    chainPriority();
    enableSpacing();
    abortAndOverflow();
    $display("tests %0d, checks %0d, failures %0d", testsRun, checksDone, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end
    else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge Clk);
    $display("watchdog expired after %0d cycles in test %s", TimeoutCycles, currentTest);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
